/* Makefile */
TOP = tb_rs_tx

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module rs_tx_top

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* hdl/ifg_deficit.sv */
`include "rs_tx_defs.svh"

module ifg_deficit (
  input  logic       clks,
  input  logic       rst_n,
  input  logic       gap_load,
  input  logic [1:0] tail_idles,
  input  logic       ifg_tick,
  output logic       gap_done
);

  logic [1:0] deficit;  // idle bytes owed, mod 4
  logic [1:0] rounds;   // idle words left in the gap
  logic [2:0] dsum;
  logic       extra;

  assign dsum  = {1'b0, deficit} + {1'b0, tail_idles};
  // wrap of the deficit, or a terminate in lane 3 leaving no idles
  assign extra = dsum[2] | (tail_idles == 2'd0);

  ////////////////////////////////////////////////////////////
  // deficit and round counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clks) begin
    if (!rst_n) begin
      deficit <= 2'd0;
      rounds  <= 2'd0;
    end else if (gap_load) begin
      deficit <= dsum[1:0];
      rounds  <= 2'(`RS_GAP_ROUNDS) + {1'b0, extra};
    end else if (ifg_tick && rounds != 2'd0) begin
      rounds  <= rounds - 2'd1;  // idles outside a gap leave it at 0
    end
  end

  assign gap_done = (rounds == 2'd1);

endmodule

/* hdl/lane_mapper.sv */
`include "rs_tx_defs.svh"

module lane_mapper import rs_tx_pkg::*; (
  input  logic                  clks,
  input  logic                  rst_n,
  input  lane_cmd_t             cmd,
  input  logic [`RS_WORD_W-1:0] held,
  input  logic [`RS_CRC_W-1:0]  crc,
  output xgmii_word_t           xgmii
);

  // words below are built in byte stream order, first byte in [31:24],
  // then flipped so that the first byte lands on lane 0
  logic [`RS_LANE_W-1:0] src;       // selected half of held
  logic [`RS_LANE_W-1:0] strm;
  logic [`RS_NLANES-1:0] ctrl;      // stream order, msb for lane 0
  logic [`RS_LANE_W-1:0] keep;      // upper bytes taken from payload
  logic [`RS_CRC_W-1:0]  crc_left;  // check bytes for the finish word
  logic [2:0]            nbytes;    // payload bytes in the tail half

  function automatic xgmii_word_t lane_word(input logic [`RS_LANE_W-1:0] s,
                                            input logic [`RS_NLANES-1:0] c);
    xgmii_word_t w;
    for (int i = 0; i < `RS_NLANES; i++) begin
      w.txd[8*i +: 8] = s[`RS_LANE_W-1-8*i -: 8];
      w.txc[i]        = c[`RS_NLANES-1-i];
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // lane fill per command
  ////////////////////////////////////////////////////////////

  always_comb begin
    src    = cmd.half ? held[`RS_LANE_W-1:0] : held[`RS_WORD_W-1:`RS_LANE_W];
    nbytes = {1'b0, cmd.tail_bytes} + 3'd1;
    keep   = ~({`RS_LANE_W{1'b1}} >> (8 * nbytes));
    strm   = {`RS_NLANES{`RS_IDLE_CH}};
    ctrl   = {`RS_NLANES{1'b1}};
    case (cmd.op)
      OP_START: begin
        strm = {`RS_START_CH, {3{`RS_PREAMBLE_CH}}};
        ctrl = 4'b1000;  // start char only
      end
      OP_PREAMBLE: begin
        strm = {{3{`RS_PREAMBLE_CH}}, `RS_SFD_CH};
        ctrl = 4'b0000;
      end
      OP_DATA: begin
        strm = src;
        ctrl = 4'b0000;
      end
      OP_TAIL: begin
        strm = (src & keep) | (crc >> (8 * nbytes));  // msb check byte first
        ctrl = 4'b0000;
      end
      OP_FINISH: begin
        strm = (crc_left & keep) |
               ({`RS_TERM_CH, {3{`RS_IDLE_CH}}} >> (8 * nbytes));
        ctrl = 4'b1111 >> nbytes;  // empty when four check bytes remain
      end
      OP_EFD: begin
        strm = {`RS_TERM_CH, {3{`RS_IDLE_CH}}};
      end
      default: ;  // idles
    endcase
  end

  // check bytes not sent with the tail word, aligned to the top
  always_ff @(posedge clks) begin
    if (cmd.op == OP_TAIL) begin
      crc_left <= crc << (8 * (3'd4 - nbytes));
    end
  end

  always_ff @(posedge clks) begin
    if (!rst_n) begin
      xgmii <= lane_word({`RS_NLANES{`RS_IDLE_CH}}, {`RS_NLANES{1'b1}});
    end else begin
      xgmii <= lane_word(strm, ctrl);
    end
  end

endmodule

/* hdl/pkt_fetch.sv */
`include "rs_tx_defs.svh"

module pkt_fetch import rs_tx_pkg::*; (
  input  logic                  clks,
  input  logic                  rst_n,
  input  pkt_word_t             pkt,
  input  logic [`RS_CRC_W-1:0]  pkt_crc,
  input  logic                  pop_pkt,
  input  logic                  pop_crc,
  input  logic                  data_adv,
  output logic [`RS_WORD_W-1:0] held,
  output logic [`RS_CRC_W-1:0]  crc,
  output logic                  half,
  output logic                  last,
  output logic [3:0]            valid_bytes
);

  // number of valid bytes in a thermometer mask
  function automatic logic [3:0] mask_bytes(input logic [7:0] mask);
    logic [3:0] n;
    n = 4'd0;
    for (int i = 0; i < 8; i++) begin
      n = n + {3'd0, mask[i]};
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // payload holding registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clks) begin
    if (pop_pkt) begin
      held <= pkt.data;
    end
    if (pop_crc) begin
      crc <= pkt_crc;
    end
  end

  ////////////////////////////////////////////////////////////
  // word status seen by the sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clks) begin
    if (!rst_n) begin
      last        <= 1'b0;
      valid_bytes <= 4'd0;
    end else if (pop_pkt) begin
      last        <= pkt.last;
      valid_bytes <= mask_bytes(pkt.mask);  // decoded once per word
    end
  end

  // which half of held goes out next
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      half <= 1'b0;
    end else if (pop_crc) begin
      half <= 1'b0;  // new frame starts on the upper half
    end else if (data_adv) begin
      half <= ~half;
    end
  end

endmodule

/* hdl/rs_tx_defs.svh */
`ifndef RS_TX_DEFS_SVH
`define RS_TX_DEFS_SVH

////////////////////////////////////////////////////////////
// xgmii control and framing characters
////////////////////////////////////////////////////////////

`define RS_IDLE_CH      8'h07   // idle, txc set
`define RS_START_CH     8'hfb   // start, lane 0 only
`define RS_PREAMBLE_CH  8'haa
`define RS_SFD_CH       8'hab   // start of frame delimiter
`define RS_TERM_CH      8'hfd   // terminate, txc set

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define RS_WORD_W       64      // upstream packet word
`define RS_LANE_W       32      // one xgmii transfer
`define RS_CRC_W        32      // frame check sequence
`define RS_NLANES       4

// minimum idle words after the terminate word,
// one more is added when the deficit wraps
`define RS_GAP_ROUNDS   2

`endif

/* hdl/rs_tx_pkg.sv */
`include "rs_tx_defs.svh"

package rs_tx_pkg;

  // word from the upstream buffer
  typedef struct packed {
    logic [`RS_WORD_W-1:0] data;  // first byte in [63:56]
    logic                  last;  // final word of the frame
    logic [7:0]            mask;  // thermometer from msb, 1 to 8 bytes
  } pkt_word_t;

  // one xgmii transfer, lane 0 in txd[7:0]
  typedef struct packed {
    logic [`RS_LANE_W-1:0] txd;
    logic [`RS_NLANES-1:0] txc;   // set per lane for control chars
  } xgmii_word_t;

  typedef enum logic [2:0] {
    WAIT_TX,
    START,
    PREAMBLE,
    DATA,
    TAIL,
    EFD,
    IFG
  } tx_state_t;

  typedef enum logic [2:0] {
    OP_IDLE,
    OP_START,
    OP_PREAMBLE,
    OP_DATA,
    OP_TAIL,     // last payload bytes plus leading check bytes
    OP_FINISH,   // stored check bytes, terminate, idles
    OP_EFD
  } lane_op_t;

  typedef struct packed {
    lane_op_t   op;
    logic       half;        // 0 selects data[63:32]
    logic [1:0] tail_bytes;  // payload bytes left in the half, minus one
  } lane_cmd_t;

endpackage

/* hdl/rs_tx_top.sv */
`include "rs_tx_defs.svh"

module rs_tx_top import rs_tx_pkg::*; (
  input  logic                 clks,
  input  logic                 rst_n,
  input  logic                 start_transmit,
  input  pkt_word_t            pkt,
  input  logic [`RS_CRC_W-1:0] pkt_crc,
  output logic                 pop_pkt,
  output logic                 pop_crc,
  output xgmii_word_t          xgmii
);

  logic [`RS_WORD_W-1:0] held;
  logic [`RS_CRC_W-1:0]  crc;
  logic                  half;
  logic                  last;
  logic [3:0]            valid_bytes;
  logic                  data_adv;
  lane_cmd_t             cmd;
  logic [1:0]            tail_idles;
  logic                  gap_load;
  logic                  gap_done;

  ////////////////////////////////////////////////////////////
  // decode, execute, result
  ////////////////////////////////////////////////////////////

  pkt_fetch u_fetch (
    .clks, .rst_n, .pkt, .pkt_crc, .pop_pkt, .pop_crc, .data_adv,
    .held, .crc, .half, .last, .valid_bytes
  );

  tx_sequencer u_seq (
    .clks, .rst_n, .start_transmit, .half, .last, .valid_bytes, .gap_done,
    .pop_pkt, .pop_crc, .data_adv, .cmd, .tail_idles, .gap_load
  );

  // every idle command counts one gap round
  ifg_deficit u_ifg (
    .clks, .rst_n, .gap_load, .tail_idles,
    .ifg_tick (cmd.op == OP_IDLE),
    .gap_done
  );

  lane_mapper u_lanes (
    .clks, .rst_n, .cmd, .held, .crc, .xgmii
  );

endmodule

/* hdl/tx_sequencer.sv */
module tx_sequencer import rs_tx_pkg::*; (
  input  logic       clks,
  input  logic       rst_n,
  input  logic       start_transmit,
  input  logic       half,
  input  logic       last,
  input  logic [3:0] valid_bytes,
  input  logic       gap_done,
  output logic       pop_pkt,
  output logic       pop_crc,
  output logic       data_adv,
  output lane_cmd_t  cmd,
  output logic [1:0] tail_idles,
  output logic       gap_load
);

  tx_state_t  state, state_nxt;
  logic [1:0] tail_q;     // tail_bytes of the tail word, kept for TAIL
  logic [1:0] tail_nxt;
  logic       tail_here;  // tail falls in the current half

  // same low bits for 1..4 in the upper half and 5..8 in the lower one
  assign tail_nxt  = valid_bytes[1:0] - 2'd1;
  assign tail_here = last & (half | (valid_bytes <= 4'd4));

  ////////////////////////////////////////////////////////////
  // state and tail registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clks) begin
    if (!rst_n) begin
      state  <= WAIT_TX;
      tail_q <= 2'd0;
    end else begin
      state <= state_nxt;
      if (state == DATA && tail_here) begin
        tail_q <= tail_nxt;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // next state and lane command
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt      = state;
    cmd.op         = OP_IDLE;
    cmd.half       = 1'b0;
    cmd.tail_bytes = 2'd0;
    case (state)
      WAIT_TX: begin
        if (start_transmit) state_nxt = START;
      end
      START: begin
        cmd.op    = OP_START;
        state_nxt = PREAMBLE;
      end
      PREAMBLE: begin
        cmd.op    = OP_PREAMBLE;
        state_nxt = DATA;
      end
      DATA: begin
        cmd.half = half;
        if (tail_here) begin
          cmd.op         = OP_TAIL;
          cmd.tail_bytes = tail_nxt;
          state_nxt      = TAIL;
        end else begin
          cmd.op = OP_DATA;
        end
      end
      TAIL: begin
        cmd.op         = OP_FINISH;
        cmd.tail_bytes = tail_q;
        // four stored check bytes fill the word, terminate goes alone
        state_nxt      = (tail_q == 2'd3) ? EFD : IFG;
      end
      EFD: begin
        cmd.op    = OP_EFD;
        state_nxt = IFG;
      end
      IFG: begin
        if (gap_done) state_nxt = start_transmit ? START : WAIT_TX;
      end
      default: state_nxt = WAIT_TX;
    endcase
  end

  assign pop_crc  = (state == START);
  assign pop_pkt  = (state == START) | ((state == DATA) & half & ~last);
  assign data_adv = (state == DATA);

  // idles after terminate in its own word, 3 when EFD follows
  assign tail_idles = 2'd2 - tail_q;
  assign gap_load   = (state == TAIL);

endmodule

/* sim/rs_tx_checker.sv */
`include "rs_tx_defs.svh"

module rs_tx_checker import rs_tx_pkg::*; (
  input logic        clks,
  input logic        rst_n,
  input logic        start_transmit,
  input logic        pop_pkt,
  input logic        pop_crc,
  input xgmii_word_t xgmii
);

  localparam int PH_IDLE = 0;
  localparam int PH_PRE  = 1;
  localparam int PH_DATA = 2;

  logic [31:0] stim [0:511];
  int          f_len [0:31];
  bit          f_b2b [0:31];
  logic [31:0] f_crc [0:31];
  int          f_off [0:31];
  int          nframes, frames_seen, errors;
  int          phase, pre_cnt, gap, exp_gap, pkt_pops, deficit;
  bit          in_frame;
  bit          start_q;   // start_transmit one cycle back
  logic [7:0]  got [$];

  initial begin
    int p;
    $readmemh("sim/rs_tx_stim.txt", stim);
    p = 0;
    nframes = 0;
    while (p < 480 && stim[p] !== 32'd0 && nframes < 32) begin
      f_len[nframes] = int'(stim[p]);
      f_b2b[nframes] = stim[p+1][0];
      f_crc[nframes] = stim[p+2];
      f_off[nframes] = p + 3;
      p = p + 3 + f_len[nframes];
      nframes++;
    end
    frames_seen = 0;
    errors = 0;
    phase = PH_IDLE;
    deficit = 0;
    gap = 0;
    exp_gap = 0;
    in_frame = 1'b0;
    start_q = 1'b0;
  end

  task automatic error(input string msg);
    errors++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // frame boundaries
  ////////////////////////////////////////////////////////////

  task automatic start_seen();
    if (frames_seen >= nframes) begin
      error("start of a frame that is not in the stimulus");
    end else if (frames_seen > 0) begin
      if (f_b2b[frames_seen]) begin
        if (gap != exp_gap)
          error($sformatf("gap of %0d bytes, expected %0d", gap, exp_gap));
      end else if (gap < exp_gap) begin
        error($sformatf("gap of %0d bytes, shorter than %0d", gap, exp_gap));
      end
    end
  endtask

  task automatic end_frame();
    int         idx, r, len;
    bit         wrap;
    logic [7:0] exp;
    idx = frames_seen;
    if (idx >= nframes) begin
      error("terminate without a frame in the stimulus");
      return;
    end
    len = f_len[idx];
    if (got.size() != len + 4) begin
      error($sformatf("frame %0d has %0d bytes, expected %0d", idx, got.size(), len + 4));
    end else begin
      for (int k = 0; k < len + 4; k++) begin
        exp = (k < len) ? stim[f_off[idx] + k][7:0] : f_crc[idx][31-8*(k-len) -: 8];
        if (got[k] != exp) begin
          error($sformatf("frame %0d byte %0d is %h, expected %h", idx, k, got[k], exp));
          break;
        end
      end
    end
    if (pkt_pops != (len + 7) / 8)
      error($sformatf("frame %0d took %0d pkt pops, expected %0d", idx, pkt_pops,
                      (len + 7) / 8));
    r = 3 - (len % 4);  // idles after terminate in its word
    wrap = (deficit + r >= 4) || (r == 0);
    exp_gap = r + 4 * (`RS_GAP_ROUNDS + int'(wrap));
    deficit = (deficit + r) % 4;
    in_frame = 1'b0;
    gap = 0;
    frames_seen++;
  endtask

  task automatic check_byte(input logic [7:0] b, input logic c, input int lane);
    case (phase)
      PH_IDLE: begin
        if (c && b == `RS_START_CH && lane == 0) begin
          start_seen();
          phase = PH_PRE;
          pre_cnt = 0;
        end else if (c && b == `RS_IDLE_CH) begin
          gap++;
        end else begin
          error($sformatf("byte %h txc %b on lane %0d between frames", b, c, lane));
        end
      end
      PH_PRE: begin
        if (c || b != ((pre_cnt == 6) ? `RS_SFD_CH : `RS_PREAMBLE_CH))
          error($sformatf("preamble byte %0d is %h txc %b", pre_cnt, b, c));
        pre_cnt++;
        if (pre_cnt == 7) begin
          phase = PH_DATA;
          got.delete();
        end
      end
      default: begin
        if (!c) begin
          got.push_back(b);
        end else if (b == `RS_TERM_CH) begin
          end_frame();
          phase = PH_IDLE;
        end else begin
          error($sformatf("control byte %h inside a frame", b));
        end
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // pops and lane stream
  ////////////////////////////////////////////////////////////

  always @(posedge clks) begin
    if (rst_n) begin
      if (pop_crc) begin
        if (!start_q) error("pop_crc without start_transmit in the cycle before");
        if (in_frame) error("pop_crc inside a frame");
        in_frame = 1'b1;
        pkt_pops = 0;
      end
      if (pop_pkt) begin
        if (!in_frame) error("pop_pkt outside a frame");
        else pkt_pops++;
      end
      for (int i = 0; i < `RS_NLANES; i++) begin
        check_byte(xgmii.txd[8*i +: 8], xgmii.txc[i], i);  // lane 0 first
      end
      start_q = start_transmit;
    end
  end

endmodule

/* sim/rs_tx_stim.txt */
// per frame: payload length, back to back flag, check sequence, then payload bytes
// a length of 0 ends the list, all values hex
01 0 1a2b3c4d  5a
02 1 00ff00ff  11 22
03 1 deadbeef  31 32 33
04 1 0badf00d  41 42 43 44
05 0 13579bdf  51 52 53 54 55
06 1 2468ace0  61 62 63 64 65 66
07 1 f0e1d2c3  71 72 73 74 75 76 77
08 1 89abcdef  81 82 83 84 85 86 87 88
0c 1 c001d00d  90 91 92 93 94 95 96 97
               98 99 9a 9b
10 0 55aa33cc  a0 a1 a2 a3 a4 a5 a6 a7
               a8 a9 aa ab ac ad ae af
13 1 7e7e8181  b0 b1 b2 b3 b4 b5 b6 b7
               b8 b9 ba bb bc bd be bf
               c0 c1 c2
09 1 31415926  d0 d1 d2 d3 d4 d5 d6 d7
               d8
0b 1 27182818  e0 e1 e2 e3 e4 e5 e6 e7
               e8 e9 ea
00

/* sim/tb_rs_tx.sv */
`include "rs_tx_defs.svh"

module tb_rs_tx import rs_tx_pkg::*; ();

  logic                 clks;
  logic                 rst_n;
  logic                 start_transmit;
  pkt_word_t            pkt;
  logic [`RS_CRC_W-1:0] pkt_crc;
  logic                 pop_pkt;
  logic                 pop_crc;
  xgmii_word_t          xgmii;

  logic [31:0]          stim [0:511];
  pkt_word_t            words [0:127];
  logic [`RS_CRC_W-1:0] crcs [0:31];
  int                   f_len [0:31];
  bit                   f_b2b [0:31];
  int                   nframes, nwords, wp, cp;
  int                   seed;
  longint               limit;
  bit                   limit_ready;

  rs_tx_top dut (
    .clks, .rst_n, .start_transmit, .pkt, .pkt_crc, .pop_pkt, .pop_crc, .xgmii
  );

  rs_tx_checker chk (
    .clks, .rst_n, .start_transmit, .pop_pkt, .pop_crc, .xgmii
  );

  always #10 clks = ~clks;

  function automatic pkt_word_t word_at(input int i);
    return (i < nwords) ? words[i] : '0;
  endfunction

  function automatic logic [31:0] crc_at(input int i);
    return (i < nframes) ? crcs[i] : '0;
  endfunction

  function automatic bit term_seen(input xgmii_word_t w);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < `RS_NLANES; i++) begin
      if (w.txc[i] && w.txd[8*i +: 8] == `RS_TERM_CH) hit = 1'b1;
    end
    return hit;
  endfunction

  ////////////////////////////////////////////////////////////
  // upstream show-ahead buffer
  ////////////////////////////////////////////////////////////

  always @(posedge clks) begin
    if (!rst_n) begin
      wp      <= 0;
      cp      <= 0;
      pkt     <= word_at(0);
      pkt_crc <= crc_at(0);
    end else begin
      if (pop_pkt) begin
        wp  <= wp + 1;
        pkt <= word_at(wp + 1);  // next word shows a cycle later
      end
      if (pop_crc) begin
        cp      <= cp + 1;
        pkt_crc <= crc_at(cp + 1);
      end
    end
  end

  initial begin
    int        p, nw, cnt, k;
    pkt_word_t pw;
    clks = 1'b0;
    rst_n = 1'b0;
    start_transmit = 1'b0;
    pkt = '0;
    pkt_crc = '0;
    seed = 97;
    nframes = 0;
    nwords = 0;
    limit_ready = 1'b0;
    $readmemh("sim/rs_tx_stim.txt", stim);
    p = 0;
    limit = 100;  // reset plus margin, in cycles
    while (p < 480 && stim[p] !== 32'd0 && nframes < 32) begin
      f_len[nframes] = int'(stim[p]);
      f_b2b[nframes] = stim[p+1][0];
      crcs[nframes]  = stim[p+2];
      nw = (f_len[nframes] + 7) / 8;
      for (int w = 0; w < nw; w++) begin
        pw = '0;
        for (int b = 0; b < 8; b++) begin
          k = w * 8 + b;
          if (k < f_len[nframes]) pw.data[63-8*b -: 8] = stim[p+3+k][7:0];
        end
        pw.last = (w == nw - 1);
        cnt = pw.last ? f_len[nframes] - 8 * w : 8;
        pw.mask = 8'(8'hff << (8 - cnt));  // thermometer from msb
        words[nwords] = pw;
        nwords++;
      end
      limit = limit + (f_len[nframes] + 12) / 4 + 6 + 13;  // frame, gap, wait
      p = p + 3 + f_len[nframes];
      nframes++;
    end
    limit = limit * 20;
    limit_ready = 1'b1;

    repeat (4) @(posedge clks);
    rst_n <= 1'b1;

    for (int i = 0; i < nframes; i++) begin
      if (i == 0 || !f_b2b[i]) begin
        repeat (5 + $unsigned($random(seed)) % 8) @(posedge clks);
        start_transmit <= 1'b1;
      end
      do @(posedge clks); while (!pop_crc);
      start_transmit <= (i + 1 < nframes) ? f_b2b[i+1] : 1'b0;
      if (i + 1 == nframes || !f_b2b[i+1]) begin
        do @(posedge clks); while (!term_seen(xgmii));
      end
    end
    repeat (8) @(posedge clks);  // let the last gap drain

    $display("frames checked: %0d of %0d, errors: %0d", chk.frames_seen, nframes,
             chk.errors);
    if (chk.frames_seen != nframes) begin
      $display("not every frame came out of the DUT");
    end
    if (chk.errors == 0 && chk.frames_seen == nframes) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_ready);
    #(limit);
    $display("watchdog: run went past %0d time units without finishing", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/rs_tx_pkg.sv
hdl/pkt_fetch.sv
hdl/tx_sequencer.sv
hdl/ifg_deficit.sv
hdl/lane_mapper.sv
hdl/rs_tx_top.sv
sim/rs_tx_checker.sv
sim/tb_rs_tx.sv
